// ==== booth_pkg.sv ====
package booth_pkg;

    // Operand and product sizes
    localparam int OPERAND_WIDTH    = 16;
    localparam int PRODUCT_WIDTH    = 2 * OPERAND_WIDTH;

    // One guard bit so that subtracting the most negative multiplicand cannot overflow
    localparam int ACC_WIDTH        = OPERAND_WIDTH + 1;

    // Radix-2 Booth retires one multiplier bit per step
    localparam int STEP_COUNT       = OPERAND_WIDTH;
    localparam int STEP_COUNT_WIDTH = 5;               // Holds 0..16

    // Queue depth of both stream FIFOs
    localparam int FIFO_DEPTH       = 4;

    // Step action, indexed by {multiplier lsb, extra low bit}
    typedef enum logic [1:0] {
        op_hold     = 2'b00,                           // Run of zeros
        op_add      = 2'b01,                           // End of a run of ones
        op_sub      = 2'b10,                           // Start of a run of ones
        op_hold_alt = 2'b11                            // Inside a run of ones
    } booth_op_t;

    // Request payload
    typedef struct packed {
        logic signed [OPERAND_WIDTH-1:0] multiplicand;
        logic signed [OPERAND_WIDTH-1:0] multiplier;
    } mul_req_t;

    // Response payload
    typedef struct packed {
        logic signed [PRODUCT_WIDTH-1:0] product;      // Two's complement product
    } mul_rsp_t;

endpackage

// ==== stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    T                         mem [DEPTH];              // Payload storage
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;                    // Occupancy 0..DEPTH
    logic                     do_write;
    logic                     do_read;

    // Full queue still takes a new item when the head leaves in the same cycle
    assign in_ready  = (count != DEPTH) || out_ready;
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign do_write = in_valid && in_ready;
    assign do_read  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (do_write && !do_read) begin
            count <= count + 1'b1;                      // Push only
        end else if (do_read && !do_write) begin
            count <= count - 1'b1;                      // Pop only
        end
    end

endmodule

// ==== booth_controller.sv ====
`timescale 1ns/1ps

module booth_controller (
    input  logic clk,
    input  logic rst,
    input  logic src_valid,
    output logic src_ready,
    input  logic dest_ready,
    output logic dest_valid,
    input  logic last_step,
    output logic load,
    output logic step_en,
    output logic capture,
    output logic clear
);

    typedef enum logic [1:0] {
        s_idle = 2'b00,                                 // Waiting for an operand pair
        s_iter = 2'b01,                                 // Booth steps running
        s_hold = 2'b10,                                 // Product offered downstream
        s_done = 2'b11                                  // Turnaround before next request
    } ctrl_state_t;

    ctrl_state_t state;
    ctrl_state_t next_state;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= s_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        // Every output gets a defined value in every state
        src_ready  = 1'b0;
        dest_valid = 1'b0;
        load       = 1'b0;
        step_en    = 1'b0;
        capture    = 1'b0;
        clear      = 1'b0;
        next_state = state;

        case (state)
            s_idle: begin
                src_ready = 1'b1;
                if (src_valid) begin
                    load       = 1'b1;                  // Latch operands, zero accumulator
                    next_state = s_iter;
                end else begin
                    clear      = 1'b1;                  // Keep working registers clean
                    next_state = s_idle;
                end
            end

            s_iter: begin
                step_en = 1'b1;
                if (last_step) begin
                    capture    = 1'b1;                  // Final step result into output reg
                    next_state = s_hold;
                end else begin
                    next_state = s_iter;
                end
            end

            s_hold: begin
                dest_valid = 1'b1;
                clear      = 1'b1;                      // Result register keeps the product
                if (dest_ready) begin
                    next_state = s_done;
                end else begin
                    next_state = s_hold;
                end
            end

            s_done: begin
                next_state = s_idle;                    // All strobes low for one cycle
            end

            default: begin
                next_state = s_idle;
            end
        endcase
    end

endmodule

// ==== booth_datapath.sv ====
`timescale 1ns/1ps

module booth_datapath (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  logic                 step_en,
    input  logic                 capture,
    input  logic                 clear,
    input  booth_pkg::mul_req_t  operands,
    input  booth_pkg::booth_op_t op_sel,
    output booth_pkg::booth_op_t booth_pair,
    output logic                 last_step,
    output booth_pkg::mul_rsp_t  result
);

    import booth_pkg::*;

    logic signed [ACC_WIDTH-1:0]    mcand;              // Sign-extended multiplicand
    logic signed [ACC_WIDTH-1:0]    acc;                // Upper half of the running product
    logic [OPERAND_WIDTH-1:0]       mplier;             // Lower half, shifts out the multiplier
    logic                           extra_bit;          // Bit shifted out of mplier last step
    logic [STEP_COUNT_WIDTH-1:0]    step_cnt;
    logic signed [ACC_WIDTH-1:0]    sum;
    logic signed [ACC_WIDTH-1:0]    acc_next;
    logic [OPERAND_WIDTH-1:0]       mplier_next;

    always_comb begin
        sum = acc;
        case (op_sel)
            op_add:              sum = acc + mcand;
            op_sub:              sum = acc - mcand;
            op_hold, op_hold_alt: sum = acc;
        endcase
    end

    // Arithmetic right shift of {acc, mplier, extra_bit}
    assign acc_next    = {sum[ACC_WIDTH-1], sum[ACC_WIDTH-1:1]};
    assign mplier_next = {sum[0], mplier[OPERAND_WIDTH-1:1]};

    assign booth_pair = booth_op_t'({mplier[0], extra_bit});
    assign last_step  = (step_cnt == STEP_COUNT_WIDTH'(STEP_COUNT - 1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            step_cnt <= '0;
        end else if (load || clear) begin
            step_cnt <= '0;
        end else if (step_en) begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            mcand     <= {operands.multiplicand[OPERAND_WIDTH-1], operands.multiplicand};
            acc       <= '0;
            mplier    <= operands.multiplier;
            extra_bit <= 1'b0;
        end else if (step_en) begin
            acc       <= acc_next;
            mplier    <= mplier_next;
            extra_bit <= mplier[0];
        end else if (clear) begin
            acc       <= '0;
            mplier    <= '0;
            extra_bit <= 1'b0;
        end
    end

    // Guard bit of acc is dropped, the product always fits in PRODUCT_WIDTH
    always_ff @(posedge clk) begin
        if (capture) begin
            result.product <= {acc_next[PRODUCT_WIDTH-OPERAND_WIDTH-1:0], mplier_next};
        end
    end

endmodule

// ==== booth_core.sv ====
`timescale 1ns/1ps

module booth_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                src_valid,
    output logic                src_ready,
    input  booth_pkg::mul_req_t src_data,
    output logic                dest_valid,
    input  logic                dest_ready,
    output booth_pkg::mul_rsp_t dest_data
);

    import booth_pkg::*;

    logic      load;
    logic      step_en;
    logic      capture;
    logic      clear;
    logic      last_step;
    booth_op_t booth_pair;                              // Next step action from the datapath

    booth_controller ctrl0 (
        .clk        (clk),
        .rst        (rst),
        .src_valid  (src_valid),
        .src_ready  (src_ready),
        .dest_ready (dest_ready),
        .dest_valid (dest_valid),
        .last_step  (last_step),
        .load       (load),
        .step_en    (step_en),
        .capture    (capture),
        .clear      (clear)
    );

    // Operands are taken straight from the stream, held stable until acceptance
    booth_datapath dp0 (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .step_en    (step_en),
        .capture    (capture),
        .clear      (clear),
        .operands   (src_data),
        .op_sel     (booth_pair),
        .booth_pair (booth_pair),
        .last_step  (last_step),
        .result     (dest_data)
    );

endmodule

// ==== booth_top.sv ====
`timescale 1ns/1ps

module booth_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    output logic                req_ready,
    input  booth_pkg::mul_req_t req,
    output logic                rsp_valid,
    input  logic                rsp_ready,
    output booth_pkg::mul_rsp_t rsp
);

    import booth_pkg::*;

    logic     core_src_valid;
    logic     core_src_ready;
    mul_req_t core_src_data;
    logic     core_dest_valid;
    logic     core_dest_ready;
    mul_rsp_t core_dest_data;

    // Queues requests while the core is busy
    stream_fifo #(
        .T     (mul_req_t),
        .DEPTH (FIFO_DEPTH)
    ) req_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req),
        .out_valid (core_src_valid),
        .out_ready (core_src_ready),
        .out_data  (core_src_data)
    );

    booth_core core0 (
        .clk        (clk),
        .rst        (rst),
        .src_valid  (core_src_valid),
        .src_ready  (core_src_ready),
        .src_data   (core_src_data),
        .dest_valid (core_dest_valid),
        .dest_ready (core_dest_ready),
        .dest_data  (core_dest_data)
    );

    // Absorbs results while the consumer stalls
    stream_fifo #(
        .T     (mul_rsp_t),
        .DEPTH (FIFO_DEPTH)
    ) rsp_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (core_dest_valid),
        .in_ready  (core_dest_ready),
        .in_data   (core_dest_data),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready),
        .out_data  (rsp)
    );

endmodule

// ==== booth_props.sv ====
`timescale 1ns/1ps

module booth_props (
    input logic                clk,
    input logic                rst,
    input logic                req_ready,
    input logic                rsp_valid,
    input logic                rsp_ready,
    input booth_pkg::mul_rsp_t rsp,
    input logic                dest_valid,
    input logic                dest_ready,
    input booth_pkg::mul_rsp_t dest_data
);

    logic out_of_reset;                                 // Low until the first edge after release

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_of_reset <= 1'b0;
        end else begin
            out_of_reset <= 1'b1;
        end
    end

    // Stalled response must not change or vanish
    rsp_stable: assert property (@(posedge clk) disable iff (!rst)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
        else $error("rsp or rsp_valid changed while rsp_ready was low");

    reset_idle: assert property (@(posedge clk)
        (rst && !out_of_reset) |-> (req_ready && !rsp_valid))
        else $error("req_ready low or rsp_valid high right after reset release");

    // Core result register holds while the response FIFO is full
    dest_stable: assert property (@(posedge clk) disable iff (!rst)
        (dest_valid && !dest_ready) |=> $stable(dest_data))
        else $error("core dest_data changed while dest_ready was low");

endmodule

bind booth_top booth_props props0 (
    .clk        (clk),
    .rst        (rst),
    .req_ready  (req_ready),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp        (rsp),
    .dest_valid (core_dest_valid),
    .dest_ready (core_dest_ready),
    .dest_data  (core_dest_data)
);

// ==== booth_tb.sv ====
`timescale 1ns/1ps

module booth_tb;

    import booth_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int IDLE_LIMIT     = 200;                // Cycles without any handshake
    localparam int STALL_LIMIT    = 60;                 // Longer than one full multiply
    localparam int RANDOM_COUNT   = 40;
    localparam int THROTTLE_COUNT = 30;

    logic     clk;
    logic     rst;
    logic     req_valid;
    logic     req_ready;
    mul_req_t req;
    logic     rsp_valid;
    logic     rsp_ready;
    mul_rsp_t rsp;

    logic [31:0]                     lcg_state;
    logic signed [PRODUCT_WIDTH-1:0] exp_q[$];          // Products of accepted requests
    mul_req_t                        pending_q[$];      // Requests still to be issued
    string                           test_name;
    int                              error_count;
    int                              test_start_errors;
    int                              tests_passed;
    int                              tests_failed;
    logic                            req_fire;
    logic                            rsp_fire;

    booth_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic mul_req_t make_req(input logic [15:0] a, input logic [15:0] b);
        mul_req_t item;
        item.multiplicand = a;
        item.multiplier   = b;
        return item;
    endfunction

    // Operands from the upper LCG bits since the low ones repeat too quickly
    function automatic mul_req_t random_req();
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = lcg_next();
        r2 = lcg_next();
        return make_req(r1[31:16], r2[31:16]);
    endfunction

    function automatic logic signed [PRODUCT_WIDTH-1:0] signed_product(input mul_req_t item);
        logic signed [PRODUCT_WIDTH-1:0] a;
        logic signed [PRODUCT_WIDTH-1:0] b;
        a = {{OPERAND_WIDTH{item.multiplicand[OPERAND_WIDTH-1]}}, item.multiplicand};
        b = {{OPERAND_WIDTH{item.multiplier[OPERAND_WIDTH-1]}}, item.multiplier};
        return a * b;
    endfunction

    task automatic check_value(input string what, input logic signed [63:0] expected,
                               input logic signed [63:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("[ERROR] %s: %s", test_name, msg);
        error_count++;
    endtask

    // Drives on the falling edge and samples the handshakes a quarter period later
    task automatic drive_cycle(input logic offer, input mul_req_t data, input logic take);
        @(negedge clk);
        req_valid = offer;
        req       = data;
        rsp_ready = take;
        #(CLK_PERIOD / 4);
        req_fire = req_valid && req_ready;
        rsp_fire = rsp_valid && rsp_ready;
        if (req_fire) begin
            exp_q.push_back(signed_product(req));
        end
        if (rsp_fire) begin
            if (exp_q.size() == 0) begin
                report_problem("response arrived with no request outstanding");
            end else begin
                check_value("product", exp_q.pop_front(), rsp.product);
            end
        end
    endtask

    // Idles with the consumer ready and counts any response that still turns up
    task automatic count_late_responses(output int late);
        late = 0;
        repeat (STALL_LIMIT) begin
            drive_cycle(1'b0, '0, 1'b1);
            if (rsp_fire) begin
                late++;
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_start_errors = error_count;
    endtask

    task automatic finish_test();
        if (error_count == test_start_errors) begin
            tests_passed++;
            $display("Test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", test_name,
                     error_count - test_start_errors);
        end
    endtask

    // Issues everything in pending_q and collects every response
    task automatic run_requests(input logic throttle);
        int          sent;
        int          got;
        int          idle;
        int          total;
        int          late;
        logic        take;
        logic [31:0] r;
        mul_req_t    item;
        sent  = 0;
        got   = 0;
        idle  = 0;
        total = pending_q.size();
        while (got < total && idle < IDLE_LIMIT) begin
            item = (sent < total) ? pending_q[sent] : '0;
            take = 1'b1;
            if (throttle) begin
                r    = lcg_next();
                take = r[27];                           // Consumer ready about half the time
            end
            drive_cycle(sent < total, item, take);
            if (req_fire) begin
                sent++;
            end
            if (rsp_fire) begin
                got++;
            end
            idle = (req_fire || rsp_fire) ? 0 : idle + 1;
        end
        if (idle >= IDLE_LIMIT) begin
            report_problem($sformatf("timed out with %0d of %0d requests sent, %0d responses",
                                     sent, total, got));
        end
        count_late_responses(late);
        check_value("response count", total, got + late);
        pending_q.delete();
        exp_q.delete();
    endtask

    task automatic reset_state_test();
        start_test("reset_state");
        @(negedge clk);
        #(CLK_PERIOD / 4);
        check_value("req_ready", 1, req_ready);
        check_value("rsp_valid", 0, rsp_valid);
        finish_test();
    endtask

    task automatic corner_operand_test();
        mul_req_t corners[$];
        start_test("corner_operands");
        corners.push_back(make_req(16'sd0, 16'sd12345));
        corners.push_back(make_req(16'sd1, -16'sd1));
        corners.push_back(make_req(16'sd32767, 16'sd32767));
        corners.push_back(make_req(16'h8000, 16'h8000));   // Most negative squared
        corners.push_back(make_req(-16'sd1, -16'sd1));
        foreach (corners[i]) begin
            pending_q.push_back(corners[i]);
            run_requests(1'b0);
        end
        finish_test();
    endtask

    task automatic random_stream_test();
        start_test("random_stream");
        repeat (RANDOM_COUNT) pending_q.push_back(random_req());
        run_requests(1'b0);
        finish_test();
    endtask

    task automatic back_pressure_test();
        int       accepted;
        int       got;
        int       idle;
        int       late;
        mul_req_t item;
        start_test("back_pressure");
        accepted = 0;
        idle     = 0;
        item     = random_req();
        // Offer until the whole chain is full and stays full
        while (idle < STALL_LIMIT && accepted <= 4 * FIFO_DEPTH) begin
            drive_cycle(1'b1, item, 1'b0);
            if (req_fire) begin
                accepted++;
                item = random_req();
                idle = 0;
            end else begin
                idle++;
            end
        end
        check_value("requests accepted while stalled", 2 * FIFO_DEPTH + 1, accepted);
        check_value("req_ready while stalled", 0, req_ready);
        got  = 0;
        idle = 0;
        while (got < accepted && idle < IDLE_LIMIT) begin
            drive_cycle(1'b0, '0, 1'b1);
            if (rsp_fire) begin
                got++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (got < accepted) begin
            report_problem($sformatf("timed out draining, %0d of %0d responses", got, accepted));
        end
        count_late_responses(late);
        check_value("responses after release", accepted, got + late);
        exp_q.delete();
        finish_test();
    endtask

    task automatic throttled_consumer_test();
        start_test("throttled_consumer");
        repeat (THROTTLE_COUNT) pending_q.push_back(random_req());
        run_requests(1'b1);
        finish_test();
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        rsp_ready    = 1'b0;
        lcg_state    = 32'h34268754;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        req_fire     = 1'b0;
        rsp_fire     = 1'b0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        reset_state_test();
        corner_operand_test();
        random_stream_test();
        back_pressure_test();
        throttled_consumer_test();

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
booth_pkg.sv
stream_fifo.sv
booth_controller.sv
booth_datapath.sv
booth_core.sv
booth_top.sv
booth_props.sv
booth_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module booth_tb -f build.f -o booth_sim

./obj_dir/booth_sim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "run.sh: testbench reported failure"
    exit 1
fi
exit 0
